//--- sources.f
src/computer_pkg.sv
src/cpu.sv
src/system_bus.sv
src/ram_8k.sv
src/rom_4k.sv
src/uart_peripheral.sv
src/computer.sv
dv/computer_tb.sv

//--- Makefile
TOP := computer_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f sources.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- dv/computer_tb.sv
module computer_tb;
    import computer_pkg::*;

    localparam int    CLK_PERIOD    = 4;
    localparam int    ECHO_CYCLES   = 2 * 10 * CLKS_PER_BIT + 200;
    localparam int    WATCHDOG_TIME = 12 * ECHO_CYCLES * CLK_PERIOD;
    localparam addr_t PORT_STORE_PC = 16'hF016;   // PC once the STA to E004 has its operands

    logic        clk;
    logic        rst_n_i;
    logic        uart_rx_i;
    logic        uart_tx_o;
    data_t       output_port_o;
    flags_t      flags_o;
    data_t       debug_b_o;
    data_t       debug_ir_o;
    addr_t       debug_pc_o;

    data_t       rx_frames[$];   // Bytes decoded from the serial output
    flags_t      port_flags;     // Flags at the store to the output port
    logic [31:0] rng_state;
    int          error_count;
    int          test_count;
    int          failed_tests;

    computer dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .uart_rx_i     (uart_rx_i),
        .uart_tx_o     (uart_tx_o),
        .output_port_o (output_port_o),
        .flags_o       (flags_o),
        .debug_b_o     (debug_b_o),
        .debug_ir_o    (debug_ir_o),
        .debug_pc_o    (debug_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired at time %0t, the echo program stopped answering", $time);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Flags are only meaningful right after ADD, before the status polls reload A
    always @(negedge clk) begin
        if (rst_n_i && debug_ir_o == data_t'(STA) && debug_pc_o == PORT_STORE_PC) begin
            port_flags <= flags_o;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic send_byte(input data_t d);
        logic [9:0] frame;
        frame = {1'b1, d, 1'b0};   // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            uart_rx_i = frame[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    task automatic recv_byte(output data_t b);
        @(negedge uart_tx_o);
        repeat (CLKS_PER_BIT / 2) @(negedge clk);   // Middle of the start bit
        for (int i = 0; i < DATA_WIDTH; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = uart_tx_o;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (uart_tx_o !== 1'b1) begin
            $display("Framing fault at time %0t, the echoed frame has no stop bit", $time);
            error_count++;
        end
    endtask

    // Serial monitor
    initial begin
        data_t b;
        wait (rst_n_i === 1'b1);
        forever begin
            recv_byte(b);
            rx_frames.push_back(b);
        end
    end

    task automatic next_frame(output data_t b);
        while (rx_frames.size() == 0) @(negedge clk);
        b = rx_frames.pop_front();
    endtask

    task automatic check_byte(input string what, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            $display("Error: %0t: %s is %h, expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_addr(input string what, input addr_t actual, input addr_t expected);
        if (actual !== expected) begin
            $display("Error: %0t: %s is %h, expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_bit(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Error: %0t: %s is %b, expected %b", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_flags(input flags_t actual, input flags_t expected);
        if (actual !== expected) begin
            $display("Error: %0t: flags z=%b c=%b n=%b, expected z=%b c=%b n=%b", $time,
                     actual.zero, actual.carry, actual.negative,
                     expected.zero, expected.carry, expected.negative);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("Test %s passed", name);
        end else begin
            failed_tests++;
            $display("Test %s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // Send one byte and check the echo against d+1
    task automatic echo_byte(input data_t d);
        data_t  expected;
        data_t  got;
        flags_t exp_flags;
        expected           = d + 8'd1;
        exp_flags.zero     = (expected == 8'h00);
        exp_flags.carry    = (d == 8'hFF);
        exp_flags.negative = expected[7];
        send_byte(d);
        next_frame(got);
        check_byte("echoed byte", got, expected);
        check_byte("output port", output_port_o, expected);
        check_byte("register B", debug_b_o, d);
        check_flags(port_flags, exp_flags);
    endtask

    task automatic reset_values();
        int errors_before;
        errors_before = error_count;
        check_addr("PC", debug_pc_o, 16'hF000);
        check_byte("IR", debug_ir_o, 8'h00);
        check_byte("register B", debug_b_o, 8'h00);
        check_byte("output port", output_port_o, 8'h00);
        check_bit("serial output", uart_tx_o, 1'b1);
        check_flags(flags_o, 3'b000);
        finish_test("reset state", errors_before);
    endtask

    task automatic single_echo();
        int errors_before;
        errors_before = error_count;
        echo_byte(8'h41);
        finish_test("single echo", errors_before);
    endtask

    task automatic wrap_echo();
        int errors_before;
        errors_before = error_count;
        echo_byte(8'hFF);
        finish_test("wrap", errors_before);
    endtask

    task automatic sign_echo();
        int errors_before;
        errors_before = error_count;
        echo_byte(8'h7F);
        finish_test("sign", errors_before);
    endtask

    task automatic random_run();
        int errors_before;
        errors_before = error_count;
        for (int n = 0; n < 8; n++) begin
            rng_state = xorshift32(rng_state);
            echo_byte(rng_state[7:0]);
        end
        finish_test("random run", errors_before);
    endtask

    initial begin
        rst_n_i      = 1'b0;
        uart_rx_i    = 1'b1;   // Idle line
        rng_state    = 32'd38;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        repeat (5) @(negedge clk);
        rst_n_i = 1'b1;
        reset_values();
        single_echo();
        wrap_echo();
        sign_echo();
        random_run();
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- src/computer.sv
module computer (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 uart_rx_i,
    output logic                 uart_tx_o,
    output computer_pkg::data_t  output_port_o,
    output computer_pkg::flags_t flags_o,
    output computer_pkg::data_t  debug_b_o,
    output computer_pkg::data_t  debug_ir_o,
    output computer_pkg::addr_t  debug_pc_o
);
    import computer_pkg::*;

    mem_req_t cpu_req;
    data_t    bus_rdata;
    data_t    ram_rdata;
    data_t    rom_rdata;
    data_t    uart_rdata;
    logic     ram_we;
    logic     uart_sel;

    cpu u_cpu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .mem_req_o   (cpu_req),
        .mem_rdata_i (bus_rdata),
        .flags_o     (flags_o),
        .debug_b_o   (debug_b_o),
        .debug_ir_o  (debug_ir_o),
        .debug_pc_o  (debug_pc_o)
    );

    system_bus u_bus (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .req_i         (cpu_req),
        .ram_rdata_i   (ram_rdata),
        .rom_rdata_i   (rom_rdata),
        .uart_rdata_i  (uart_rdata),
        .ram_we_o      (ram_we),
        .uart_sel_o    (uart_sel),
        .rdata_o       (bus_rdata),
        .output_port_o (output_port_o)
    );

    // 0000-1FFF
    ram_8k u_ram (
        .clk     (clk),
        .we_i    (ram_we),
        .addr_i  (cpu_req.addr[12:0]),
        .wdata_i (cpu_req.wdata),
        .rdata_o (ram_rdata)
    );

    // F000-FFFF
    rom_4k u_rom (
        .clk     (clk),
        .addr_i  (cpu_req.addr[11:0]),
        .rdata_o (rom_rdata)
    );

    uart_peripheral u_uart (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .address_offset_i (cpu_req.addr[1:0]),
        .cmd_enable_i     (uart_sel),
        .cmd_write_i      (cpu_req.write),
        .cmd_read_i       (cpu_req.read),
        .parallel_data_i  (cpu_req.wdata),
        .parallel_data_o  (uart_rdata),
        .serial_rx_i      (uart_rx_i),
        .serial_tx_o      (uart_tx_o)
    );

endmodule

//--- src/uart_peripheral.sv
module uart_peripheral (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic [1:0]          address_offset_i,
    input  logic                cmd_enable_i,
    input  logic                cmd_write_i,
    input  logic                cmd_read_i,
    input  computer_pkg::data_t parallel_data_i,
    output computer_pkg::data_t parallel_data_o,
    input  logic                serial_rx_i,
    output logic                serial_tx_o
);
    import computer_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    logic                  wr_data;
    logic                  rd_data;
    uart_status_t          status;

    // Transmitter
    logic                  tx_busy_q;
    logic [DATA_WIDTH+1:0] tx_frame_q;   // Stop bit, byte and start bit, LSB on the line
    logic [3:0]            tx_bits_q;
    logic [BAUD_WIDTH-1:0] tx_baud_q;
    logic                  tx_tick;

    // Receiver
    logic [1:0]            rx_sync_q;
    logic                  rx_line;
    rx_state_e             rx_state_q;
    logic [2:0]            rx_bits_q;
    logic [BAUD_WIDTH-1:0] rx_baud_q;
    logic                  rx_tick;
    logic                  rx_capture;
    logic                  rx_valid_q;
    data_t                 rx_shift_q;
    data_t                 rx_data_q;

    assign wr_data    = cmd_enable_i && cmd_write_i && (address_offset_i == UART_DATA);
    assign rd_data    = cmd_enable_i && cmd_read_i && (address_offset_i == UART_DATA);
    assign tx_tick    = (tx_baud_q == BAUD_WIDTH'(CLKS_PER_BIT - 1));
    assign rx_tick    = (rx_baud_q == BAUD_WIDTH'(CLKS_PER_BIT - 1));
    assign rx_line    = rx_sync_q[1];
    assign rx_capture = (rx_state_q == RX_STOP) && rx_tick && rx_line;  // Good stop bit

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_busy_q  <= 1'b0;
            tx_frame_q <= '1;
            tx_bits_q  <= '0;
            tx_baud_q  <= '0;
        end else if (wr_data && !tx_busy_q) begin
            tx_busy_q  <= 1'b1;
            tx_frame_q <= {1'b1, parallel_data_i, 1'b0};
            tx_bits_q  <= '0;
            tx_baud_q  <= '0;
        end else if (tx_busy_q) begin
            tx_baud_q <= tx_tick ? '0 : tx_baud_q + 1'b1;
            if (tx_tick) begin
                tx_frame_q <= {1'b1, tx_frame_q[DATA_WIDTH+1:1]};
                tx_bits_q  <= tx_bits_q + 1'b1;
                if (tx_bits_q == 4'd9) tx_busy_q <= 1'b0;   // Stop bit done
            end
        end
    end

    assign serial_tx_o = tx_frame_q[0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_sync_q  <= 2'b11;
            rx_state_q <= RX_IDLE;
            rx_bits_q  <= '0;
            rx_baud_q  <= '0;
            rx_valid_q <= 1'b0;
        end else begin
            rx_sync_q <= {rx_sync_q[0], serial_rx_i};
            case (rx_state_q)
                RX_IDLE: begin
                    rx_baud_q <= '0;
                    if (!rx_line) rx_state_q <= RX_START;
                end
                RX_START: begin
                    rx_baud_q <= rx_baud_q + 1'b1;
                    if (rx_baud_q == BAUD_WIDTH'(CLKS_PER_BIT / 2 - 1)) begin
                        rx_baud_q  <= '0;
                        rx_bits_q  <= '0;
                        rx_state_q <= rx_line ? RX_IDLE : RX_DATA;  // Reject glitches
                    end
                end
                RX_DATA: begin
                    rx_baud_q <= rx_tick ? '0 : rx_baud_q + 1'b1;
                    if (rx_tick) begin
                        rx_bits_q <= rx_bits_q + 1'b1;
                        if (rx_bits_q == 3'd7) rx_state_q <= RX_STOP;
                    end
                end
                default: begin
                    rx_baud_q <= rx_tick ? '0 : rx_baud_q + 1'b1;
                    if (rx_tick) rx_state_q <= RX_IDLE;
                end
            endcase
            // A new byte wins over a read in the same cycle
            if (rx_capture)   rx_valid_q <= 1'b1;
            else if (rd_data) rx_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if ((rx_state_q == RX_DATA) && rx_tick) rx_shift_q <= {rx_line, rx_shift_q[DATA_WIDTH-1:1]};
        if (rx_capture) rx_data_q <= rx_shift_q;
    end

    always_comb begin
        status          = '0;
        status.rx_valid = rx_valid_q;
        status.tx_busy  = tx_busy_q;
        case (address_offset_i)
            UART_STATUS: parallel_data_o = status;
            UART_DATA:   parallel_data_o = rx_data_q;
            default:     parallel_data_o = '0;   // No control register
        endcase
    end

endmodule

//--- src/rom_4k.sv
module rom_4k (
    input  logic                clk,
    input  logic [11:0]         addr_i,
    output computer_pkg::data_t rdata_o
);
    import computer_pkg::*;

    data_t rom_byte;

    // Echo program, linked at F000
    always_comb begin
        case (addr_i)
            // Wait for a received byte, the transmitter is idle here
            12'h000: rom_byte = LDA;
            12'h001: rom_byte = 8'h01;   // E001 status
            12'h002: rom_byte = 8'hE0;
            12'h003: rom_byte = JZ;
            12'h004: rom_byte = 8'h00;
            12'h005: rom_byte = 8'hF0;
            12'h006: rom_byte = LDA;
            12'h007: rom_byte = 8'h02;   // E002 data, clears rx_valid
            12'h008: rom_byte = 8'hE0;
            12'h009: rom_byte = STA;
            12'h00A: rom_byte = 8'h10;   // Copy kept at 0010
            12'h00B: rom_byte = 8'h00;
            12'h00C: rom_byte = LDA;
            12'h00D: rom_byte = 8'h10;
            12'h00E: rom_byte = 8'h00;
            12'h00F: rom_byte = MOVBA;
            12'h010: rom_byte = LDI;
            12'h011: rom_byte = 8'h01;
            12'h012: rom_byte = ADD;
            12'h013: rom_byte = STA;
            12'h014: rom_byte = 8'h04;   // Output port
            12'h015: rom_byte = 8'hE0;
            12'h016: rom_byte = STA;
            12'h017: rom_byte = 8'h11;
            12'h018: rom_byte = 8'h00;
            // Wait for the transmitter
            12'h019: rom_byte = LDA;
            12'h01A: rom_byte = 8'h01;
            12'h01B: rom_byte = 8'hE0;
            12'h01C: rom_byte = JNZ;
            12'h01D: rom_byte = 8'h19;
            12'h01E: rom_byte = 8'hF0;
            12'h01F: rom_byte = LDA;
            12'h020: rom_byte = 8'h11;
            12'h021: rom_byte = 8'h00;
            12'h022: rom_byte = STA;
            12'h023: rom_byte = 8'h02;
            12'h024: rom_byte = 8'hE0;
            // Let the frame finish so tx_busy is clear at the top
            12'h025: rom_byte = LDA;
            12'h026: rom_byte = 8'h01;
            12'h027: rom_byte = 8'hE0;
            12'h028: rom_byte = JNZ;
            12'h029: rom_byte = 8'h25;
            12'h02A: rom_byte = 8'hF0;
            12'h02B: rom_byte = JMP;
            12'h02C: rom_byte = 8'h00;
            12'h02D: rom_byte = 8'hF0;
            default: rom_byte = NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        rdata_o <= rom_byte;
    end

endmodule

//--- src/ram_8k.sv
module ram_8k (
    input  logic                clk,
    input  logic                we_i,
    input  logic [12:0]         addr_i,
    input  computer_pkg::data_t wdata_i,
    output computer_pkg::data_t rdata_o
);
    import computer_pkg::*;

    data_t mem [8192];

    always_ff @(posedge clk) begin
        if (we_i) mem[addr_i] <= wdata_i;
        rdata_o <= mem[addr_i];   // Old data on a write to the same address
    end

endmodule

//--- src/system_bus.sv
module system_bus (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  computer_pkg::mem_req_t req_i,
    input  computer_pkg::data_t    ram_rdata_i,
    input  computer_pkg::data_t    rom_rdata_i,
    input  computer_pkg::data_t    uart_rdata_i,
    output logic                   ram_we_o,
    output logic                   uart_sel_o,
    output computer_pkg::data_t    rdata_o,
    output computer_pkg::data_t    output_port_o
);
    import computer_pkg::*;

    typedef struct packed {
        logic ram;
        logic rom;
        logic uart;
    } dev_sel_t;

    dev_sel_t sel;
    dev_sel_t rd_sel_q;   // Owner of the read data in this cycle
    logic     led_sel;
    data_t    uart_q;
    data_t    port_q;

    // Address decode
    always_comb begin
        sel.ram  = (req_i.addr[ADDR_WIDTH-1 -: 3] == 3'b000);       // 0000-1FFF
        sel.rom  = (req_i.addr[ADDR_WIDTH-1 -: 4] == 4'hF);         // F000-FFFF
        sel.uart = (req_i.addr[ADDR_WIDTH-1:2] == UART_BASE[ADDR_WIDTH-1:2]);
        led_sel  = (req_i.addr == LED_ADDR);
    end

    assign ram_we_o   = req_i.write && sel.ram;
    assign uart_sel_o = sel.uart;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_sel_q <= '0;
            port_q   <= '0;
        end else begin
            rd_sel_q <= req_i.read ? sel : '0;
            if (req_i.write && led_sel) port_q <= req_i.wdata;
        end
    end

    // Matches the one-cycle latency of the memories
    always_ff @(posedge clk) begin
        uart_q <= uart_rdata_i;
    end

    always_comb begin
        rdata_o = '0;   // Unmapped reads
        if (rd_sel_q.ram)       rdata_o = ram_rdata_i;
        else if (rd_sel_q.rom)  rdata_o = rom_rdata_i;
        else if (rd_sel_q.uart) rdata_o = uart_q;
    end

    assign output_port_o = port_q;

endmodule

//--- src/cpu.sv
module cpu (
    input  logic                   clk,
    input  logic                   rst_n_i,
    output computer_pkg::mem_req_t mem_req_o,
    input  computer_pkg::data_t    mem_rdata_i,
    output computer_pkg::flags_t   flags_o,
    output computer_pkg::data_t    debug_b_o,
    output computer_pkg::data_t    debug_ir_o,
    output computer_pkg::addr_t    debug_pc_o
);
    import computer_pkg::*;

    cpu_state_e state_q;
    logic       phase_q;     // High in the data cycle of a read
    opcode_e    ir_q;
    addr_t      pc_q;
    addr_t      operand_q;   // Immediate or 16-bit address, little endian
    data_t      a_q;
    data_t      b_q;
    data_t      mdr_q;
    flags_t     flags_q;

    data_t      a_next;
    logic       carry_next;
    logic       flags_upd;

    // Bus request
    always_comb begin
        mem_req_o = '0;
        case (state_q)
            FETCH: begin
                mem_req_o.addr = pc_q;
                mem_req_o.read = 1'b1;
            end
            OPER_LO, OPER_HI: begin
                mem_req_o.addr = pc_q;
                mem_req_o.read = ~phase_q;
            end
            MEM_READ: begin
                mem_req_o.addr = operand_q;
                mem_req_o.read = ~phase_q && (ir_q == LDA);  // ADD and SUB idle here
            end
            EXECUTE: begin
                if (ir_q == STA) begin
                    mem_req_o.addr  = operand_q;
                    mem_req_o.wdata = a_q;
                    mem_req_o.write = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // ALU and new accumulator value
    always_comb begin
        a_next     = a_q;
        carry_next = flags_q.carry;
        flags_upd  = 1'b0;
        case (ir_q)
            LDI: begin
                a_next    = operand_q[DATA_WIDTH-1:0];
                flags_upd = 1'b1;
            end
            LDA: begin
                a_next    = mdr_q;
                flags_upd = 1'b1;
            end
            ADD: begin
                {carry_next, a_next} = {1'b0, a_q} + {1'b0, b_q};
                flags_upd            = 1'b1;
            end
            SUB: begin
                {carry_next, a_next} = {1'b0, a_q} - {1'b0, b_q};  // Bit 8 is the borrow
                flags_upd            = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= FETCH;
            phase_q <= 1'b0;
            ir_q    <= NOP;
            pc_q    <= RESET_VECTOR;
            a_q     <= '0;
            b_q     <= '0;
            flags_q <= '0;
        end else begin
            case (state_q)
                FETCH: state_q <= DECODE;
                DECODE: begin
                    ir_q <= opcode_e'(mem_rdata_i);
                    pc_q <= pc_q + 16'd1;
                    case (opcode_e'(mem_rdata_i))
                        LDI, LDA, STA, JMP, JZ, JNZ: state_q <= OPER_LO;
                        ADD, SUB:                    state_q <= MEM_READ;
                        default:                     state_q <= EXECUTE;  // Unknown acts as NOP
                    endcase
                end
                OPER_LO: begin
                    phase_q <= ~phase_q;
                    if (phase_q) begin
                        pc_q    <= pc_q + 16'd1;
                        state_q <= (ir_q == LDI) ? EXECUTE : OPER_HI;
                    end
                end
                OPER_HI: begin
                    phase_q <= ~phase_q;
                    if (phase_q) begin
                        pc_q    <= pc_q + 16'd1;
                        state_q <= (ir_q == LDA) ? MEM_READ : EXECUTE;
                    end
                end
                MEM_READ: begin
                    phase_q <= ~phase_q;
                    if (phase_q) state_q <= EXECUTE;
                end
                EXECUTE: begin
                    state_q <= FETCH;
                    a_q     <= a_next;
                    if (flags_upd) begin
                        flags_q.zero     <= (a_next == '0);
                        flags_q.carry    <= carry_next;
                        flags_q.negative <= a_next[DATA_WIDTH-1];
                    end
                    case (ir_q)
                        MOVBA:   b_q <= a_q;
                        JMP:     pc_q <= operand_q;
                        JZ:      if (flags_q.zero) pc_q <= operand_q;
                        JNZ:     if (!flags_q.zero) pc_q <= operand_q;
                        default: ;
                    endcase
                end
                default: state_q <= FETCH;
            endcase
        end
    end

    // Operand and memory data capture
    always_ff @(posedge clk) begin
        if (phase_q) begin
            case (state_q)
                OPER_LO:  operand_q[DATA_WIDTH-1:0]          <= mem_rdata_i;
                OPER_HI:  operand_q[ADDR_WIDTH-1:DATA_WIDTH] <= mem_rdata_i;
                MEM_READ: mdr_q                              <= mem_rdata_i;
                default: ;
            endcase
        end
    end

    assign flags_o    = flags_q;
    assign debug_b_o  = b_q;
    assign debug_ir_o = ir_q;
    assign debug_pc_o = pc_q;

endmodule

//--- src/computer_pkg.sv
package computer_pkg;

    localparam int DATA_WIDTH = 8;
    localparam int ADDR_WIDTH = 16;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Memory map
    localparam addr_t RESET_VECTOR = 16'hF000;     // Start of program ROM
    localparam addr_t UART_BASE    = 16'hE000;
    localparam addr_t LED_ADDR     = 16'hE004;
    localparam logic [1:0] UART_STATUS = 2'd1;
    localparam logic [1:0] UART_DATA   = 2'd2;

    // Serial timing
    localparam int CLKS_PER_BIT = 8;
    localparam int BAUD_WIDTH   = $clog2(CLKS_PER_BIT);

    // Zero is NOP so unused ROM space runs through harmlessly
    typedef enum logic [7:0] {
        NOP   = 8'h00,
        LDI   = 8'h01,
        LDA   = 8'h02,
        STA   = 8'h03,
        MOVBA = 8'h04,
        ADD   = 8'h05,
        SUB   = 8'h06,
        JMP   = 8'h07,
        JZ    = 8'h08,
        JNZ   = 8'h09
    } opcode_e;

    typedef enum logic [2:0] {FETCH, DECODE, OPER_LO, OPER_HI, MEM_READ, EXECUTE} cpu_state_e;

    typedef struct packed {
        addr_t addr;
        data_t wdata;
        logic  read;
        logic  write;
    } mem_req_t;

    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
    } flags_t;

    typedef struct packed {
        logic [DATA_WIDTH-3:0] pad;
        logic                  tx_busy;
        logic                  rx_valid;   // Bit 0
    } uart_status_t;

endpackage
